//--- build.f
+incdir+rtl
rtl/vp_pkg.sv
rtl/rom_bus_if.sv
rtl/clk_enable_gen.sv
rtl/cart_loader.sv
rtl/cart_bank_map.sv
rtl/cart_rom_arbiter.sv
rtl/palette_lut.sv
rtl/videopac_cart_top.sv
testbench/tb_videopac_cart.sv

//--- testbench/tb_videopac_cart.sv
////////////////////////////////////////
// Self-checking testbench for the Videopac cartridge wrapper
// Loads random images, replays a mapping table, checks enables and palette
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_cfg.svh"

module tb_videopac_cart;

	// One console access and where it should land in ROM
	typedef struct {
		vp_pkg::cart_kind_e    kind;
		logic [11:0]           addr;
		logic                  bs0;
		logic                  bs1;
		logic                  cs_n;
		logic                  psen_n;
		logic                  rd;
		logic [`VP_ROM_AW-1:0] offset;
	} row_t;

	// One image download
	typedef struct {
		vp_pkg::cart_kind_e kind;
		int                 nbytes;
		logic               xrom;
	} image_t;

	logic                   clk_sys;
	logic                   reset;
	logic                   pal_i;
	logic [2:0]             contrast_i;
	logic                   dl_active_i;
	logic                   dl_wr_i;
	logic                   dl_is_xrom_i;
	logic [`VP_ROM_AW-1:0]  dl_addr_i;
	logic [7:0]             dl_data_i;
	logic [`VP_CART_AW-1:0] cart_addr_i;
	logic                   cart_bs0_i;
	logic                   cart_bs1_i;
	logic                   cart_cs_n_i;
	logic                   cart_psen_n_i;
	logic [3:0]             color_i;
	logic [7:0]             cart_data_o;
	logic                   cpu_en_o;
	logic                   vdc_en_o;
	logic [7:0]             vga_r_o;
	logic [7:0]             vga_g_o;
	logic [7:0]             vga_b_o;

	logic [7:0] model_mem [0:`VP_ROM_DEPTH-1];
	logic [7:0] last_byte;
	int         errors;
	int         timeouts;
	int         checks;

	////////////////////////////////////////
	// Mapping table, offsets worked out by hand
	////////////////////////////////////////

	// kind, addr, bs0, bs1, cs_n, psen_n, read expected, ROM offset
	row_t rows [0:18] = '{
		'{vp_pkg::CART_4K,   12'h000, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 14'h0000},
		'{vp_pkg::CART_4K,   12'h3ff, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 14'h0bff},
		'{vp_pkg::CART_4K,   12'h855, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 14'h0455},
		'{vp_pkg::CART_4K,   12'hc2a, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 14'h0c2a},
		'{vp_pkg::CART_4K,   12'h555, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 14'h0000},
		'{vp_pkg::CART_8K,   12'h7ff, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 14'h13ff},
		'{vp_pkg::CART_8K,   12'h801, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 14'h1c01},
		'{vp_pkg::CART_8K,   12'h123, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 14'h0923},
		'{vp_pkg::CART_16K,  12'habc, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 14'h3abc},
		'{vp_pkg::CART_16K,  12'h456, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 14'h2456},
		'{vp_pkg::CART_16K,  12'hfff, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 14'h1fff},
		'{vp_pkg::CART_2K,   12'hfff, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 14'h07ff},
		'{vp_pkg::CART_2K,   12'h5a5, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 14'h01a5},
		'{vp_pkg::CART_2K,   12'hb00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 14'h0700},
		'{vp_pkg::CART_XROM, 12'h9ab, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 14'h09ab},
		'{vp_pkg::CART_XROM, 12'h234, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 14'h0234},
		'{vp_pkg::CART_XROM, 12'h777, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 14'h0000},
		'{vp_pkg::CART_XROM, 12'hf00, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 14'h0000},
		'{vp_pkg::CART_XROM, 12'hfed, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 14'h0fed}
	};

	// Download order, 3000 bytes falls back to the 2K class
	image_t images [0:4] = '{
		'{vp_pkg::CART_4K,   `VP_SIZE_4K,  1'b0},
		'{vp_pkg::CART_8K,   `VP_SIZE_8K,  1'b0},
		'{vp_pkg::CART_16K,  `VP_SIZE_16K, 1'b0},
		'{vp_pkg::CART_2K,   3000,         1'b0},
		'{vp_pkg::CART_XROM, `VP_SIZE_4K,  1'b1}
	};

	videopac_cart_top UUT (.*);

	always #10 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Next rising edge plus drive skew
	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic value_error(input string name, input logic [23:0] exp, input logic [23:0] act);
		$display("[ERROR] time %0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
		errors++;
	endtask

	// Console bus back to no access in every class
	task automatic bus_idle();
		cart_psen_n_i = 1'b1;
		cart_cs_n_i   = 1'b1;
		cart_bs0_i    = 1'b1;
		cart_bs1_i    = 1'b1;
	endtask

	// Spacing in clocks between two pulses of one enable
	task automatic measure_period(input bit use_vdc, input int exp_period);
		int    n;
		bit    seen;
		string name;
		name = use_vdc ? "vdc_en_o" : "cpu_en_o";
		n    = 0;
		seen = 1'b0;
		while (!seen && n < 40) begin
			step();
			n++;
			seen = use_vdc ? vdc_en_o : cpu_en_o;
		end
		if (!seen) begin
			$display("Timed out waiting for a first %s pulse", name);
			timeouts++;
		end else begin
			n    = 0;
			seen = 1'b0;
			while (!seen && n < 40) begin
				step();
				n++;
				seen = use_vdc ? vdc_en_o : cpu_en_o;
			end
			checks++;
			if (!seen) begin
				$display("Timed out waiting for a second %s pulse", name);
				timeouts++;
			end else if (n != exp_period) begin
				value_error({name, " period"}, 24'(exp_period), 24'(n));
			end
		end
	endtask

	// Random image into the DUT and the model, start cycle carries no write
	task automatic load_image(input int nbytes, input logic xrom);
		logic [7:0] data;
		dl_active_i  = 1'b1;
		dl_is_xrom_i = xrom;
		step();
		for (int i = 0; i < nbytes; i++) begin
			data         = 8'($urandom);
			model_mem[i] = data;
			dl_wr_i      = 1'b1;
			dl_addr_i    = 14'(i);
			dl_data_i    = data;
			step();
		end
		dl_wr_i      = 1'b0;
		dl_active_i  = 1'b0;
		dl_is_xrom_i = 1'b0;
		step();
	endtask

	// One console access, data checked a clock later
	task automatic apply_row(input row_t r);
		logic [7:0] exp;
		cart_addr_i   = r.addr;
		cart_bs0_i    = r.bs0;
		cart_bs1_i    = r.bs1;
		cart_cs_n_i   = r.cs_n;
		cart_psen_n_i = r.psen_n;
		step();
		// No read means the old byte stays
		exp = r.rd ? model_mem[r.offset] : last_byte;
		checks++;
		if (cart_data_o !== exp) begin
			value_error("cart_data_o", 24'(exp), 24'(cart_data_o));
		end
		last_byte = exp;
		bus_idle();
	endtask

	// Greyscale reference built from the two package tables
	function automatic logic [23:0] expected_rgb(input logic [3:0] idx, input logic [2:0] lvl);
		logic [23:0] p;
		int          r;
		int          g;
		int          b;
		int          hi;
		int          lo;
		int          k;
		int          mr;
		int          mg;
		int          mb;
		int          grey;
		if (lvl == 3'd0) begin
			return vp_pkg::pal_ntsc[idx];
		end
		p = vp_pkg::pal_pal[idx];
		r = p[23:16];
		g = p[15:8];
		b = p[7:0];
		if (lvl == 3'd4) begin
			mr = r;
			mg = g;
			mb = b;
		end else begin
			k  = (lvl == 3'd1 || lvl == 3'd7) ? 1 : ((lvl == 3'd2 || lvl == 3'd6) ? 2 : 4);
			// Upper levels trade red for blue
			hi = (lvl > 3'd4) ? b : r;
			lo = (lvl > 3'd4) ? r : b;
			mr = ((hi >> k) << k) | (lo >> (8 - k));
			mg = ((g >> (8 - k)) << (8 - k)) | (hi >> k);
			mb = mr;
		end
		grey = (`VP_GREY_WR * mr + `VP_GREY_WG * mg + `VP_GREY_WB * mb) / 256;
		return {grey[7:0], grey[7:0], grey[7:0]};
	endfunction

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		logic [2:0]  levels [3];
		logic [23:0] exp_rgb;
		int          b_addr;
		logic [7:0]  new_byte;
		levels = '{3'd0, 3'd4, 3'd7};
		errors    = 0;
		timeouts  = 0;
		checks    = 0;
		last_byte = 8'd0;
		void'($urandom(83015));
		clk_sys      = 1'b0;
		reset        = 1'b1;
		pal_i        = 1'b0;
		contrast_i   = 3'd0;
		dl_active_i  = 1'b0;
		dl_wr_i      = 1'b0;
		dl_is_xrom_i = 1'b0;
		dl_addr_i    = '0;
		dl_data_i    = 8'd0;
		cart_addr_i  = '0;
		color_i      = 4'd0;
		bus_idle();

		// Enables stay quiet through reset
		for (int i = 0; i < 3; i++) begin
			step();
			checks++;
			if (cpu_en_o !== 1'b0 || vdc_en_o !== 1'b0) begin
				$display("Clock enable pulsed while reset was high");
				errors++;
			end
		end
		reset = 1'b0;
		checks++;
		if ({vga_r_o, vga_g_o, vga_b_o} !== 24'd0) begin
			value_error("vga_rgb", 24'd0, {vga_r_o, vga_g_o, vga_b_o});
		end

		// NTSC then PAL ratios
		measure_period(1'b0, `VP_CPU_DIV_NTSC);
		measure_period(1'b1, `VP_VDC_DIV_NTSC);
		pal_i = 1'b1;
		measure_period(1'b0, `VP_CPU_DIV_PAL);
		measure_period(1'b1, `VP_VDC_DIV_PAL);
		pal_i = 1'b0;

		// Each image class with its slice of the table
		foreach (images[li]) begin
			load_image(images[li].nbytes, images[li].xrom);
			foreach (rows[ri]) begin
				if (rows[ri].kind == images[li].kind) begin
					apply_row(rows[ri]);
				end
			end
		end

		// Read colliding with a download write, XROM class kept
		b_addr = 0;
		while (b_addr < 4095 && model_mem[b_addr] === last_byte) begin
			b_addr++;
		end
		dl_active_i  = 1'b1;
		dl_is_xrom_i = 1'b1;
		step();
		new_byte           = ~model_mem[14'h0c3c];
		model_mem[14'h0c3c] = new_byte;
		dl_wr_i       = 1'b1;
		dl_addr_i     = 14'h0c3c;
		dl_data_i     = new_byte;
		cart_addr_i   = 12'(b_addr);
		cart_psen_n_i = 1'b1;
		cart_cs_n_i   = 1'b0;
		step();
		checks++;
		if (cart_data_o !== last_byte) begin
			value_error("cart_data_o", 24'(last_byte), 24'(cart_data_o));
		end
		dl_wr_i      = 1'b0;
		dl_active_i  = 1'b0;
		dl_is_xrom_i = 1'b0;
		bus_idle();
		step();
		apply_row('{vp_pkg::CART_XROM, 12'hc3c, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 14'h0c3c});

		// Palette sweep
		foreach (levels[li]) begin
			for (int c = 0; c < 16; c++) begin
				color_i    = 4'(c);
				contrast_i = levels[li];
				step();
				exp_rgb = expected_rgb(4'(c), levels[li]);
				checks++;
				if (vga_r_o !== exp_rgb[23:16]) begin
					value_error("vga_r_o", 24'(exp_rgb[23:16]), 24'(vga_r_o));
				end
				if (vga_g_o !== exp_rgb[15:8]) begin
					value_error("vga_g_o", 24'(exp_rgb[15:8]), 24'(vga_g_o));
				end
				if (vga_b_o !== exp_rgb[7:0]) begin
					value_error("vga_b_o", 24'(exp_rgb[7:0]), 24'(vga_b_o));
				end
			end
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/videopac_cart_top.sv
////////////////////////////////////////
// Videopac cartridge, clock-enable and palette wrapper
// Console core sits outside and connects through the plain ports
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_cfg.svh"

module videopac_cart_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   pal_i,
	input  logic [2:0]             contrast_i,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  logic                   dl_is_xrom_i,
	input  logic [`VP_ROM_AW-1:0]  dl_addr_i,
	input  logic [7:0]             dl_data_i,
	input  logic [`VP_CART_AW-1:0] cart_addr_i,
	input  logic                   cart_bs0_i,
	input  logic                   cart_bs1_i,
	input  logic                   cart_cs_n_i,
	input  logic                   cart_psen_n_i,
	input  logic [3:0]             color_i,
	output logic [7:0]             cart_data_o,
	output logic                   cpu_en_o,
	output logic                   vdc_en_o,
	output logic [7:0]             vga_r_o,
	output logic [7:0]             vga_g_o,
	output logic [7:0]             vga_b_o
);

	vp_pkg::cart_kind_e cart_kind;
	logic [23:0]        rgb;

	// Download side and console side of the ROM
	rom_bus_if load_bus ();
	rom_bus_if read_bus ();

	clk_enable_gen u_clk_en (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	cart_loader u_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active_i  (dl_active_i),
		.dl_wr_i      (dl_wr_i),
		.dl_is_xrom_i (dl_is_xrom_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.kind_o       (cart_kind),
		.bus          (load_bus.requester)
	);

	cart_bank_map u_bank_map (
		.kind_i        (cart_kind),
		.cart_addr_i   (cart_addr_i),
		.cart_bs0_i    (cart_bs0_i),
		.cart_bs1_i    (cart_bs1_i),
		.cart_cs_n_i   (cart_cs_n_i),
		.cart_psen_n_i (cart_psen_n_i),
		.cart_data_o   (cart_data_o),
		.bus           (read_bus.requester)
	);

	cart_rom_arbiter u_rom (
		.clk_sys  (clk_sys),
		.load_bus (load_bus.arbiter),
		.read_bus (read_bus.arbiter)
	);

	palette_lut u_palette (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.color_i    (color_i),
		.contrast_i (contrast_i),
		.rgb_o      (rgb)
	);

	// Split packed colour for the VGA side
	assign vga_r_o = rgb[23:16];
	assign vga_g_o = rgb[15:8];
	assign vga_b_o = rgb[7:0];

endmodule

//--- rtl/palette_lut.sv
////////////////////////////////////////
// VDC colour index to 24-bit RGB, one clock of latency
// Nonzero contrast selects the G7200 greyscale from the PAL table
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_cfg.svh"

module palette_lut (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [3:0]  color_i,
	input  logic [2:0]  contrast_i,
	output logic [23:0] rgb_o
);

	logic [23:0] ntsc_c;
	logic [23:0] pal_c;
	logic [3:0]  k;
	logic        swap;
	logic [7:0]  hi_b;
	logic [7:0]  lo_b;
	logic [7:0]  mix_r;
	logic [7:0]  mix_g;
	logic [7:0]  mix_b;
	logic [15:0] grey_sum;
	logic [23:0] rgb_d;

	// Index is {red, green, blue, luma}
	assign ntsc_c = vp_pkg::pal_ntsc[color_i];
	assign pal_c  = vp_pkg::pal_pal[color_i];

	////////////////////////////////////////
	// Contrast mixing
	////////////////////////////////////////

	// Bits borrowed per level, upper levels swap red and blue
	always_comb begin
		swap = contrast_i[2];
		case (contrast_i)
			3'd1, 3'd7: k = 4'd1;
			3'd2, 3'd6: k = 4'd2;
			3'd3, 3'd5: k = 4'd4;
			default:    k = 4'd0;
		endcase
	end

	assign hi_b = swap ? pal_c[7:0] : pal_c[23:16];
	assign lo_b = swap ? pal_c[23:16] : pal_c[7:0];

	always_comb begin
		if (contrast_i == 3'd4) begin
			// Plain PAL colour
			mix_r = pal_c[23:16];
			mix_g = pal_c[15:8];
			mix_b = pal_c[7:0];
		end else begin
			// Top 8-k of one channel, then top k of the other
			mix_r = (hi_b & (8'hff << k)) | (lo_b >> (4'd8 - k));
			mix_g = (pal_c[15:8] & (8'hff << (4'd8 - k))) | (hi_b >> k);
			mix_b = mix_r;
		end
	end

	////////////////////////////////////////
	// Greyscale and output register
	////////////////////////////////////////

	// Weighted luma, truncated
	assign grey_sum = 16'(`VP_GREY_WR) * {8'd0, mix_r}
		+ 16'(`VP_GREY_WG) * {8'd0, mix_g}
		+ 16'(`VP_GREY_WB) * {8'd0, mix_b};

	assign rgb_d = (contrast_i == 3'd0) ? ntsc_c
		: {grey_sum[15:8], grey_sum[15:8], grey_sum[15:8]};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o <= 24'd0;
		end else begin
			rgb_o <= rgb_d;
		end
	end

endmodule

//--- rtl/cart_rom_arbiter.sv
////////////////////////////////////////
// Shared 16 KiB cartridge ROM with a two-peer priority arbiter
// Loader wins over the console reader, a losing read is dropped
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_cfg.svh"

module cart_rom_arbiter (
	input  logic        clk_sys,
	rom_bus_if.arbiter  load_bus,
	rom_bus_if.arbiter  read_bus
);

	vp_pkg::rom_owner_e    owner;
	logic [7:0]            rom_mem [0:`VP_ROM_DEPTH-1];
	logic [7:0]            rdata_q;
	logic [`VP_ROM_AW-1:0] sel_addr;
	logic                  sel_we;
	logic [7:0]            sel_wdata;

	////////////////////////////////////////
	// Owner select
	////////////////////////////////////////

	always_comb begin
		if (load_bus.req) begin
			owner = vp_pkg::OWN_LOADER;
		end else if (read_bus.req) begin
			owner = vp_pkg::OWN_READER;
		end else begin
			owner = vp_pkg::OWN_NONE;
		end
	end

	// Grants in the request cycle
	assign load_bus.gnt = (owner == vp_pkg::OWN_LOADER);
	assign read_bus.gnt = (owner == vp_pkg::OWN_READER);

	// Port mux toward the single RAM port
	always_comb begin
		case (owner)
			vp_pkg::OWN_LOADER: begin
				sel_addr  = load_bus.addr;
				sel_we    = load_bus.we;
				sel_wdata = load_bus.wdata;
			end
			vp_pkg::OWN_READER: begin
				sel_addr  = read_bus.addr;
				sel_we    = read_bus.we;
				sel_wdata = read_bus.wdata;
			end
			default: begin
				sel_addr  = read_bus.addr;
				sel_we    = 1'b0;
				sel_wdata = 8'd0;
			end
		endcase
	end

	////////////////////////////////////////
	// ROM array
	////////////////////////////////////////

	// Write at the edge, read data one clock later and held
	always_ff @(posedge clk_sys) begin
		if (owner != vp_pkg::OWN_NONE) begin
			if (sel_we) begin
				rom_mem[sel_addr] <= sel_wdata;
			end else begin
				rdata_q <= rom_mem[sel_addr];
			end
		end
	end

	assign load_bus.rdata = rdata_q;
	assign read_bus.rdata = rdata_q;

	// One owner at a time
	a_one_grant: assert property (
		@(posedge clk_sys) !(load_bus.gnt && read_bus.gnt)
	);

	// Console side must never reach the write port
	a_wr_only_loader: assert property (
		@(posedge clk_sys) (owner != vp_pkg::OWN_NONE && sel_we) |-> load_bus.gnt
	);

endmodule

//--- rtl/cart_bank_map.sv
////////////////////////////////////////
// Console cartridge bus to ROM address and read request
// Mapping follows the size class latched by the loader
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_cfg.svh"

module cart_bank_map (
	input  vp_pkg::cart_kind_e     kind_i,
	input  logic [`VP_CART_AW-1:0] cart_addr_i,
	input  logic                   cart_bs0_i,
	input  logic                   cart_bs1_i,
	input  logic                   cart_cs_n_i,
	input  logic                   cart_psen_n_i,
	output logic [7:0]             cart_data_o,
	rom_bus_if.requester           bus
);

	logic                  rd_cond;
	logic [`VP_ROM_AW-1:0] rom_addr;

	////////////////////////////////////////
	// Read condition
	////////////////////////////////////////

	// XROM is read as data space, psen high with cs_n or bs0 low
	always_comb begin
		if (kind_i == vp_pkg::CART_XROM) begin
			rd_cond = cart_psen_n_i & (~cart_cs_n_i | ~cart_bs0_i);
		end else begin
			rd_cond = ~cart_psen_n_i;
		end
	end

	////////////////////////////////////////
	// Address mapping
	////////////////////////////////////////

	// A10 is skipped on banked images
	always_comb begin
		case (kind_i)
			vp_pkg::CART_XROM: begin
				rom_addr = {2'b00, cart_addr_i};
			end
			vp_pkg::CART_4K: begin
				rom_addr = {2'b00, cart_bs0_i, cart_addr_i[11], cart_addr_i[9:0]};
			end
			vp_pkg::CART_8K: begin
				rom_addr = {1'b0, cart_bs1_i, cart_bs0_i, cart_addr_i[11], cart_addr_i[9:0]};
			end
			vp_pkg::CART_16K: begin
				// Full 12 address bits per bank
				rom_addr = {cart_bs1_i, cart_bs0_i, cart_addr_i};
			end
			default: begin
				// 2K and odd sizes
				rom_addr = {3'b000, cart_addr_i[11], cart_addr_i[9:0]};
			end
		endcase
	end

	// Read-only peer
	assign bus.req   = rd_cond;
	assign bus.we    = 1'b0;
	assign bus.addr  = rom_addr;
	assign bus.wdata = 8'd0;

	// Held by the arbiter until the next granted read
	assign cart_data_o = bus.rdata;

endmodule

//--- rtl/cart_loader.sv
////////////////////////////////////////
// Download write path into cartridge ROM
// Counts image bytes and derives the size class for the mapper
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_cfg.svh"

module cart_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active_i,
	input  logic                  dl_wr_i,
	input  logic                  dl_is_xrom_i,
	input  logic [`VP_ROM_AW-1:0] dl_addr_i,
	input  logic [7:0]            dl_data_i,
	output vp_pkg::cart_kind_e    kind_o,
	rom_bus_if.requester          bus
);

	logic        dl_active_q;
	logic        dl_start;
	logic        wr_req;
	logic        xrom_q;
	logic [15:0] byte_cnt;

	// Start of a new download
	assign dl_start = dl_active_i & ~dl_active_q;
	assign wr_req   = dl_active_i & dl_wr_i;

	// Every download strobe is a ROM write
	assign bus.req   = wr_req;
	assign bus.we    = wr_req;
	assign bus.addr  = dl_addr_i;
	assign bus.wdata = dl_data_i;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			xrom_q      <= 1'b0;
			byte_cnt    <= 16'd0;
		end else begin
			dl_active_q <= dl_active_i;
			if (dl_start) begin
				// A write in the start cycle of a fresh image counts too
				byte_cnt <= {15'd0, dl_wr_i};
				xrom_q   <= dl_is_xrom_i;
			end else if (wr_req) begin
				byte_cnt <= byte_cnt + 16'd1;
			end
		end
	end

	// Only exact image sizes get a banked class
	always_comb begin
		if (xrom_q) begin
			kind_o = vp_pkg::CART_XROM;
		end else begin
			case (byte_cnt)
				16'(`VP_SIZE_4K):  kind_o = vp_pkg::CART_4K;
				16'(`VP_SIZE_8K):  kind_o = vp_pkg::CART_8K;
				16'(`VP_SIZE_16K): kind_o = vp_pkg::CART_16K;
				default:           kind_o = vp_pkg::CART_2K;
			endcase
		end
	end

	// Strobes only come inside a download window
	a_wr_in_dl: assert property (
		@(posedge clk_sys) disable iff (reset) dl_wr_i |-> dl_active_i
	);

endmodule

//--- rtl/clk_enable_gen.sv
////////////////////////////////////////
// CPU and VDC clock-enable pulses from the system clock
// Period follows pal_i, a change takes effect at the next wrap
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_cfg.svh"

module clk_enable_gen (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Slot 0 is the CPU, slot 1 the VDC
	logic [3:0] cnt [2];
	logic [3:0] last [2];
	logic [1:0] en_q;

	// Terminal counts, one below the period
	assign last[0] = pal_i ? 4'(`VP_CPU_DIV_PAL - 1) : 4'(`VP_CPU_DIV_NTSC - 1);
	assign last[1] = pal_i ? 4'(`VP_VDC_DIV_PAL - 1) : 4'(`VP_VDC_DIV_NTSC - 1);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cnt[0] <= 4'd0;
			cnt[1] <= 4'd0;
			en_q   <= 2'b00;
		end else begin
			for (int i = 0; i < 2; i++) begin
				// >= so a shorter PAL/NTSC period still wraps
				if (cnt[i] >= last[i]) begin
					cnt[i]  <= 4'd0;
					en_q[i] <= 1'b1;
				end else begin
					cnt[i]  <= cnt[i] + 4'd1;
					en_q[i] <= 1'b0;
				end
			end
		end
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

	// No enable edge may escape while the console is held in reset
	a_no_en_in_reset: assert property (
		@(posedge clk_sys) reset |-> !$rose(cpu_en_o) && !$rose(vdc_en_o)
	);

endmodule

//--- rtl/rom_bus_if.sv
////////////////////////////////////////
// One requester's path into the shared cartridge ROM
// Requester drives the access, arbiter answers with grant and data
////////////////////////////////////////
`timescale 1ns/1ps
`include "vp_cfg.svh"

interface rom_bus_if;

	// Access request, write enable and location
	logic                  req;
	logic                  we;
	logic [`VP_ROM_AW-1:0] addr;
	logic [7:0]            wdata;

	// Same-cycle grant, read data one clock after a granted read
	logic                  gnt;
	logic [7:0]            rdata;

	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

//--- rtl/vp_pkg.sv
////////////////////////////////////////
// Shared types and colour tables for the cartridge wrapper
////////////////////////////////////////
package vp_pkg;

	// Image size class, picks the bank mapping
	typedef enum logic [2:0] {
		CART_2K,
		CART_4K,
		CART_8K,
		CART_16K,
		CART_XROM
	} cart_kind_e;

	// Holder of the shared ROM port this cycle
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_LOADER,
		OWN_READER
	} rom_owner_e;

	// Calibrated NTSC colours, index is {r, g, b, luma}
	parameter logic [23:0] pal_ntsc [0:15] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};

	// PAL colours, source for the G7200 greyscale
	parameter logic [23:0] pal_pal [0:15] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

endpackage

//--- rtl/vp_cfg.svh
////////////////////////////////////////
// Sizing and ratio constants for the Videopac cartridge wrapper
// Include in any RTL file that needs divider counts, widths or weights
////////////////////////////////////////
`ifndef VP_CFG_SVH
`define VP_CFG_SVH

// Enable periods in sys clocks, NTSC vs PAL
`define VP_CPU_DIV_NTSC 8
`define VP_CPU_DIV_PAL  12
`define VP_VDC_DIV_NTSC 6
`define VP_VDC_DIV_PAL  10

// Cartridge ROM geometry
`define VP_ROM_AW    14
`define VP_ROM_DEPTH 16384
`define VP_CART_AW   12

// Image byte counts that pick a size class
`define VP_SIZE_4K  4096
`define VP_SIZE_8K  8192
`define VP_SIZE_16K 16384

// Luma weights out of 256
`define VP_GREY_WR 77
`define VP_GREY_WG 150
`define VP_GREY_WB 29

`endif
